// ==== sources.f ====
logic/clock_pkg.sv
logic/tick_mode_decode.sv
logic/bcd_time_counter.sv
logic/countdown_timer.sv
logic/alarm_match.sv
logic/display_format.sv
logic/clock_top.sv
tests/clock_chk.sv
tests/clock_checker.sv
tests/clock_tb.sv

// ==== tests/clock_tb.sv ====
`timescale 1ns/100ps

module clock_tb;

  import clock_pkg::*;

  localparam int TPS       = 8;  // clk cycles per second in the DUT
  localparam int SEED      = 86221;
  localparam int DRV_DELAY = 2;

  localparam logic [2:0] T_IDLE       = 3'd0;
  localparam logic [2:0] T_COUNT      = 3'd1;
  localparam logic [2:0] T_HOUR12     = 3'd2;
  localparam logic [2:0] T_TIMER      = 3'd3;
  localparam logic [2:0] T_ALARM_SET  = 3'd4;
  localparam logic [2:0] T_ALARM_RING = 3'd5;
  localparam logic [2:0] T_SET_HOLD   = 3'd6;

  logic              clk;
  logic              rst;
  mode_e             mode;
  logic [TIME_W-1:0] time_in;
  logic              show_timer;
  logic              hour12;
  logic [TIME_W-1:0] disp_time;
  logic              pm;
  logic              buzzer;
  logic              ring;
  logic [2:0]        test_id;
  int                err_count;
  int                check_count;
  int                timeouts;
  logic [HM_W-1:0]   alarm;
  int                alarm_min;

  clock_top #(.TICKS_PER_SEC(TPS)) dut0 (
    .clk        (clk),
    .rst        (rst),
    .mode       (mode),
    .time_in    (time_in),
    .show_timer (show_timer),
    .hour12     (hour12),
    .disp_time  (disp_time),
    .pm         (pm),
    .buzzer     (buzzer),
    .ring       (ring)
  );

  clock_checker mon0 (
    .clk         (clk),
    .rst         (rst),
    .test_id     (test_id),
    .time_in     (time_in),
    .disp_time   (disp_time),
    .pm          (pm),
    .buzzer      (buzzer),
    .ring        (ring),
    .err_count   (err_count),
    .check_count (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [7:0] bcd_pair(input int n);
    return {4'(n / 10), 4'(n % 10)};
  endfunction

  function automatic logic [TIME_W-1:0] random_time();
    return {bcd_pair($urandom % 24), bcd_pair($urandom % 60), bcd_pair($urandom % 60)};
  endfunction

  // inputs change just after the rising edge
  task automatic run_cycles(input int n);
    repeat (n) @(posedge clk);
    #(DRV_DELAY);
  endtask

  task automatic wait_for_disp(input logic [TIME_W-1:0] target, input int limit,
                               input string what);
    int n;
    n = 0;
    while (disp_time !== target && n < limit) begin
      run_cycles(1);
      n++;
    end
    if (disp_time !== target) begin
      timeouts++;
      $display("Timeout: %s did not happen within %0d cycles", what, limit);
    end
  endtask

  task automatic wait_for_ring(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (ring !== level && n < limit) begin
      run_cycles(1);
      n++;
    end
    if (ring !== level) begin
      timeouts++;
      $display("Timeout: %s did not happen within %0d cycles", what, limit);
    end
  endtask

  // set mode, then back to run once mode_q has followed
  task automatic load_clock(input logic [TIME_W-1:0] t);
    test_id = T_IDLE;
    mode    = mode_set_time;
    time_in = t;
    run_cycles(3);
    mode = mode_run;
    run_cycles(2);
  endtask

  initial begin
    void'($urandom(SEED));
    rst        = 1'b1;
    mode       = mode_run;
    time_in    = '0;
    show_timer = 1'b0;
    hour12     = 1'b0;
    test_id    = T_IDLE;
    timeouts   = 0;
    run_cycles(5);
    rst = 1'b0;
    run_cycles(2);

    for (int i = 0; i < 3; i++) begin
      load_clock(random_time());
      test_id = T_COUNT;
      run_cycles(4 * TPS);
    end
    load_clock(24'h235958);
    test_id = T_COUNT;
    wait_for_disp(24'h000000, 4 * TPS, "clock rollover to 00:00:00");
    run_cycles(TPS);

    hour12 = 1'b1;
    for (int h = 0; h < 24; h++) begin
      load_clock({bcd_pair(h), 16'h0000});
      test_id = T_HOUR12;
      run_cycles(4);
    end
    hour12 = 1'b0;

    test_id    = T_IDLE;
    show_timer = 1'b1;
    mode       = mode_set_timer;
    time_in    = 24'h000005;
    run_cycles(3);
    mode = mode_run;
    run_cycles(2);
    test_id = T_TIMER;
    wait_for_disp(24'h000000, 8 * TPS, "timer reaching 00:00:00");
    run_cycles(3 * TPS);  // must hold at zero
    test_id    = T_IDLE;
    show_timer = 1'b0;

    alarm_min = 1 + $urandom % 59;
    alarm     = {bcd_pair($urandom % 24), bcd_pair(alarm_min)};
    mode      = mode_set_alarm;
    time_in   = {alarm, 8'h00};
    run_cycles(3);
    test_id = T_ALARM_SET;
    run_cycles(4);
    // alarm keeps loading until mode_q leaves set mode
    test_id = T_IDLE;
    mode    = mode_run;
    run_cycles(2);
    load_clock({alarm[15:8], bcd_pair(alarm_min - 1), 8'h59});
    test_id = T_ALARM_RING;
    wait_for_ring(1'b1, 4 * TPS, "ring rising at the alarm minute");
    wait_for_ring(1'b0, 62 * TPS, "ring falling after the alarm minute");
    run_cycles(2);

    test_id = T_IDLE;
    mode    = mode_set_time;
    time_in = random_time();
    run_cycles(3);
    test_id = T_SET_HOLD;
    run_cycles(4 * TPS);
    test_id = T_IDLE;
    mode    = mode_run;
    run_cycles(2);

    $display("checks %0d, value errors %0d, timeouts %0d, assertion errors %0d",
             check_count, err_count, timeouts, dut0.u_chk.assert_errors);
    if (err_count == 0 && timeouts == 0 && dut0.u_chk.assert_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== tests/clock_checker.sv ====
`timescale 1ns/100ps

module clock_checker (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [2:0]                  test_id,
  input  logic [clock_pkg::TIME_W-1:0] time_in,
  input  logic [clock_pkg::TIME_W-1:0] disp_time,
  input  logic                        pm,
  input  logic                        buzzer,
  input  logic                        ring,
  output int                          err_count,
  output int                          check_count
);

  import clock_pkg::*;

  localparam logic [2:0] T_IDLE       = 3'd0;
  localparam logic [2:0] T_COUNT      = 3'd1;
  localparam logic [2:0] T_HOUR12     = 3'd2;
  localparam logic [2:0] T_TIMER      = 3'd3;
  localparam logic [2:0] T_ALARM_SET  = 3'd4;
  localparam logic [2:0] T_ALARM_RING = 3'd5;
  localparam logic [2:0] T_SET_HOLD   = 3'd6;

  logic [TIME_W-1:0] prev_disp;
  logic              have_prev;
  logic [2:0]        last_id;
  logic [HM_W-1:0]   alarm_ref;  // alarm seen while it was set
  string             name;

  function automatic int bcd_to_int(input logic [7:0] b);
    return b[7:4] * 10 + b[3:0];
  endfunction

  function automatic logic [7:0] int_to_bcd(input int n);
    return {4'(n / 10), 4'(n % 10)};
  endfunction

  // reference model works on a plain second count
  function automatic int to_seconds(input logic [TIME_W-1:0] t);
    return bcd_to_int(t[23:16]) * 3600 + bcd_to_int(t[15:8]) * 60 + bcd_to_int(t[7:0]);
  endfunction

  function automatic logic [TIME_W-1:0] from_seconds(input int s);
    return {int_to_bcd(s / 3600), int_to_bcd((s / 60) % 60), int_to_bcd(s % 60)};
  endfunction

  function automatic logic [TIME_W-1:0] next_second(input logic [TIME_W-1:0] t);
    return from_seconds((to_seconds(t) + 1) % 86400);
  endfunction

  function automatic logic [TIME_W-1:0] prev_second(input logic [TIME_W-1:0] t);
    int s;
    s = to_seconds(t);
    return (s == 0) ? t : from_seconds(s - 1);  // timer stops at zero
  endfunction

  function automatic logic [7:0] hour_12(input logic [7:0] h);
    int n;
    n = bcd_to_int(h) % 12;
    if (n == 0) begin
      n = 12;
    end
    return int_to_bcd(n);
  endfunction

  function automatic string test_name(input logic [2:0] id);
    case (id)
      T_COUNT:      return "time counting";
      T_HOUR12:     return "12-hour format";
      T_TIMER:      return "countdown timer";
      T_ALARM_SET:  return "alarm display";
      T_ALARM_RING: return "alarm ring";
      T_SET_HOLD:   return "set mode hold";
      default:      return "idle";
    endcase
  endfunction

  task automatic compare_value(input string test, input logic [TIME_W-1:0] expected,
                               input logic [TIME_W-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("Error %s: expected %h, actual %h at %0t", test, expected, actual, $time);
    end
  endtask

  task automatic compare_flag(input string test, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("Error %s: expected %b, actual %b at %0t", test, expected, actual, $time);
    end
  endtask

  // sampled mid cycle, away from edges and input changes
  always @(negedge clk) begin
    if (rst) begin
      have_prev   = 1'b0;
      last_id     = T_IDLE;
      err_count   = 0;
      check_count = 0;
    end else begin
      if (test_id != last_id) begin
        have_prev = 1'b0;  // new test, no history yet
      end
      name = test_name(test_id);
      case (test_id)
        T_COUNT, T_ALARM_RING: begin
          if (have_prev && disp_time != prev_disp) begin
            compare_value(name, next_second(prev_disp), disp_time);
          end
          compare_flag({name, " pm"}, bcd_to_int(disp_time[23:16]) >= 12, pm);
          if (test_id == T_ALARM_RING && have_prev) begin
            // ring lags the matching minute by one cycle
            compare_flag({name, " ring"}, prev_disp[23:8] == alarm_ref, ring);
          end
        end
        T_HOUR12: begin
          compare_value(name, {8'h00, hour_12(time_in[23:16]), time_in[15:8]},
                        {8'h00, disp_time[23:8]});
          compare_flag({name, " pm"}, bcd_to_int(time_in[23:16]) >= 12, pm);
        end
        T_TIMER: begin
          if (have_prev && disp_time != prev_disp) begin
            compare_value(name, prev_second(prev_disp), disp_time);
          end
          compare_flag({name, " buzzer"}, disp_time == '0, buzzer);
        end
        T_ALARM_SET: begin
          alarm_ref = time_in[23:8];
          compare_value(name, {time_in[23:8], 8'h00}, disp_time);
        end
        T_SET_HOLD: begin
          compare_value(name, time_in, disp_time);
        end
        default: begin
        end
      endcase
      prev_disp = disp_time;
      have_prev = 1'b1;
      last_id   = test_id;
    end
  end

endmodule

// ==== tests/clock_chk.sv ====
`timescale 1ns/100ps

module clock_chk (
  input logic             clk,
  input logic             rst,
  input logic             tick,
  input clock_pkg::mode_e mode_q,
  input logic             load_time,
  input logic             time_step,
  input logic             pm,
  input logic             buzzer,
  input logic             ring
);

  import clock_pkg::*;

  int assert_errors = 0;  // read by the testbench at the end

  // prescaler pulse is one cycle wide
  tick_single: assert property (@(posedge clk) disable iff (rst) tick |=> !tick)
    else begin
      $error("tick stayed high for two cycles");
      assert_errors++;
    end

  pm_run_only: assert property (@(posedge clk) disable iff (rst) (mode_q != mode_run) |-> !pm)
    else begin
      $error("pm high outside run mode");
      assert_errors++;
    end

  quiet_after_reset: assert property (@(posedge clk) rst |=> (!buzzer && !ring))
    else begin
      $error("buzzer or ring active right after reset");
      assert_errors++;
    end

  load_or_step: assert property (@(posedge clk) disable iff (rst) !(load_time && time_step))
    else begin
      $error("load_time and time_step high together");
      assert_errors++;
    end

endmodule

bind clock_top clock_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .tick      (tick),
  .mode_q    (mode_q),
  .load_time (load_time),
  .time_step (time_step),
  .pm        (pm),
  .buzzer    (buzzer),
  .ring      (ring)
);

// ==== logic/clock_top.sv ====
`timescale 1ns/100ps

module clock_top #(
  parameter int TICKS_PER_SEC = 50_000_000
) (
  input  logic                        clk,
  input  logic                        rst,
  input  clock_pkg::mode_e             mode,
  input  logic [clock_pkg::TIME_W-1:0] time_in,
  input  logic                        show_timer,
  input  logic                        hour12,
  output logic [clock_pkg::TIME_W-1:0] disp_time,
  output logic                        pm,
  output logic                        buzzer,
  output logic                        ring
);

  import clock_pkg::*;

  logic              tick;
  mode_e             mode_q;
  logic              load_time;
  logic              load_timer;
  logic              load_alarm;
  logic              time_step;
  logic              timer_step;
  logic [TIME_W-1:0] clock_time;
  logic [TIME_W-1:0] timer_time;
  logic [HM_W-1:0]   alarm_hm;

  tick_mode_decode #(
    .TICKS_PER_SEC(TICKS_PER_SEC)
  ) u_decode (
    .clk        (clk),
    .rst        (rst),
    .mode       (mode),
    .tick       (tick),
    .mode_q     (mode_q),
    .load_time  (load_time),
    .load_timer (load_timer),
    .load_alarm (load_alarm),
    .time_step  (time_step),
    .timer_step (timer_step)
  );

  bcd_time_counter u_clock (
    .clk        (clk),
    .rst        (rst),
    .load_time  (load_time),
    .time_step  (time_step),
    .time_in    (time_in),
    .clock_time (clock_time)
  );

  countdown_timer u_timer (
    .clk        (clk),
    .rst        (rst),
    .load_timer (load_timer),
    .timer_step (timer_step),
    .time_in    (time_in),
    .timer_time (timer_time),
    .buzzer     (buzzer)
  );

  // alarm compares hh:mm only
  alarm_match u_alarm (
    .clk        (clk),
    .rst        (rst),
    .load_alarm (load_alarm),
    .alarm_in   (time_in[TIME_W-1 -: HM_W]),
    .clock_hm   (clock_time[TIME_W-1 -: HM_W]),
    .alarm_hm   (alarm_hm),
    .ring       (ring)
  );

  display_format u_display (
    .mode_q     (mode_q),
    .show_timer (show_timer),
    .hour12     (hour12),
    .clock_time (clock_time),
    .timer_time (timer_time),
    .alarm_hm   (alarm_hm),
    .disp_time  (disp_time),
    .pm         (pm)
  );

endmodule

// ==== logic/display_format.sv ====
`timescale 1ns/100ps

module display_format (
  input  clock_pkg::mode_e             mode_q,
  input  logic                        show_timer,
  input  logic                        hour12,
  input  logic [clock_pkg::TIME_W-1:0] clock_time,
  input  logic [clock_pkg::TIME_W-1:0] timer_time,
  input  logic [clock_pkg::HM_W-1:0]   alarm_hm,
  output logic [clock_pkg::TIME_W-1:0] disp_time,
  output logic                        pm
);

  import clock_pkg::*;

  logic [TIME_W-1:0] src_time;
  logic [7:0]        src_hour;
  logic [TIME_W-9:0] src_rest;  // mm:ss
  logic              run_clock;

  // 24h bcd hour to its 12h form
  function automatic logic [7:0] hour_to_12(input logic [7:0] hr);
    logic [7:0] res;
    if (hr == 8'h00) begin
      res = BCD_NOON;  // midnight reads 12
    end else if (hr > BCD_NOON) begin
      if (hr[3:0] < 4'h2) begin
        res = {hr[7:4] - 4'h2, hr[3:0] + 4'h8};  // 20 and 21 borrow a ten
      end else begin
        res = {hr[7:4] - 4'h1, hr[3:0] - 4'h2};
      end
    end else begin
      res = hr;  // 01 to 12 unchanged
    end
    return res;
  endfunction

  // timer first, then alarm while it is being set, else the clock
  always_comb begin
    if (show_timer) begin
      src_time = timer_time;
    end else if (mode_q == mode_set_alarm) begin
      src_time = {alarm_hm, {(TIME_W - HM_W){1'b0}}};
    end else begin
      src_time = clock_time;
    end
  end

  assign {src_hour, src_rest} = src_time;

  assign run_clock = !show_timer && (mode_q == mode_run);
  assign pm        = run_clock && (src_hour >= BCD_NOON);

  assign disp_time = (run_clock && hour12) ? {hour_to_12(src_hour), src_rest}
                                           : src_time;

endmodule

// ==== logic/alarm_match.sv ====
`timescale 1ns/100ps

module alarm_match (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      load_alarm,
  input  logic [clock_pkg::HM_W-1:0] alarm_in,
  input  logic [clock_pkg::HM_W-1:0] clock_hm,
  output logic [clock_pkg::HM_W-1:0] alarm_hm,
  output logic                      ring
);

  import clock_pkg::*;

  logic [HM_W-1:0] alarm_q;
  logic            alarm_valid;  // set once any alarm was stored

  assign alarm_hm = alarm_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      alarm_q     <= '0;
      alarm_valid <= 1'b0;
      ring        <= 1'b0;
    end else begin
      if (load_alarm) begin
        alarm_q     <= alarm_in;
        alarm_valid <= 1'b1;
      end
      // seconds not compared, so ring covers the whole minute
      ring <= alarm_valid && (clock_hm == alarm_q);
    end
  end

endmodule

// ==== logic/countdown_timer.sv ====
`timescale 1ns/100ps

module countdown_timer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        load_timer,
  input  logic                        timer_step,
  input  logic [clock_pkg::TIME_W-1:0] time_in,
  output logic [clock_pkg::TIME_W-1:0] timer_time,
  output logic                        buzzer
);

  import clock_pkg::*;

  logic [7:0] hour_q;
  logic [7:0] min_q;
  logic [7:0] sec_q;
  logic       armed;
  logic       timer_zero;
  logic       sec_borrow;
  logic       min_borrow;

  // one bcd digit pair down, 00 turns into wrap_val
  function automatic logic [7:0] bcd_dec(input logic [7:0] val,
                                         input logic [7:0] wrap_val);
    logic [7:0] res;
    if (val == 8'h00) begin
      res = wrap_val;
    end else if (val[3:0] == 4'h0) begin
      res = {val[7:4] - 4'h1, 4'h9};  // borrow from tens
    end else begin
      res = val - 8'h01;
    end
    return res;
  endfunction

  assign timer_time = {hour_q, min_q, sec_q};
  assign timer_zero = (timer_time == '0);
  assign sec_borrow = (sec_q == 8'h00);
  assign min_borrow = sec_borrow && (min_q == 8'h00);

  assign buzzer = armed && timer_zero;

  always_ff @(posedge clk) begin
    if (rst) begin
      hour_q <= 8'h00;
      min_q  <= 8'h00;
      sec_q  <= 8'h00;
      armed  <= 1'b0;
    end else if (load_timer) begin
      {hour_q, min_q, sec_q} <= time_in;
      if (time_in != '0) begin
        armed <= 1'b1;
      end
    end else if (timer_step && !timer_zero) begin
      sec_q <= bcd_dec(sec_q, BCD_MAX_MINSEC);
      if (sec_borrow) begin
        min_q <= bcd_dec(min_q, BCD_MAX_MINSEC);
      end
      if (min_borrow) begin
        // hours are nonzero here, no wrap needed
        hour_q <= bcd_dec(hour_q, 8'h00);
      end
    end
  end

endmodule

// ==== logic/bcd_time_counter.sv ====
`timescale 1ns/100ps

module bcd_time_counter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        load_time,
  input  logic                        time_step,
  input  logic [clock_pkg::TIME_W-1:0] time_in,
  output logic [clock_pkg::TIME_W-1:0] clock_time
);

  import clock_pkg::*;

  logic [7:0] hour_q;
  logic [7:0] min_q;
  logic [7:0] sec_q;
  logic [7:0] hour_in;
  logic [7:0] min_in;
  logic [7:0] sec_in;
  logic       sec_wrap;
  logic       min_wrap;

  // one bcd digit pair up, rolls to 00 past max_val
  function automatic logic [7:0] bcd_inc(input logic [7:0] val,
                                         input logic [7:0] max_val);
    logic [7:0] res;
    if (val == max_val) begin
      res = 8'h00;
    end else if (val[3:0] == 4'h9) begin
      res = {val[7:4] + 4'h1, 4'h0};  // units carry into tens
    end else begin
      res = val + 8'h01;
    end
    return res;
  endfunction

  assign {hour_in, min_in, sec_in} = time_in;
  assign clock_time = {hour_q, min_q, sec_q};

  // carries between fields
  assign sec_wrap = (sec_q == BCD_MAX_MINSEC);
  assign min_wrap = sec_wrap && (min_q == BCD_MAX_MINSEC);

  always_ff @(posedge clk) begin
    if (rst) begin
      hour_q <= 8'h00;
      min_q  <= 8'h00;
      sec_q  <= 8'h00;
    end else if (load_time) begin
      // load wins, a coinciding step is dropped
      hour_q <= hour_in;
      min_q  <= min_in;
      sec_q  <= sec_in;
    end else if (time_step) begin
      sec_q <= bcd_inc(sec_q, BCD_MAX_MINSEC);
      if (sec_wrap) begin
        min_q <= bcd_inc(min_q, BCD_MAX_MINSEC);
      end
      if (min_wrap) begin
        hour_q <= bcd_inc(hour_q, BCD_MAX_HOUR);  // 23 back to 00
      end
    end
  end

endmodule

// ==== logic/tick_mode_decode.sv ====
`timescale 1ns/100ps

module tick_mode_decode #(
  parameter int TICKS_PER_SEC = 50_000_000
) (
  input  logic             clk,
  input  logic             rst,
  input  clock_pkg::mode_e mode,
  output logic             tick,
  output clock_pkg::mode_e mode_q,
  output logic             load_time,
  output logic             load_timer,
  output logic             load_alarm,
  output logic             time_step,
  output logic             timer_step
);

  import clock_pkg::*;

  localparam int CNT_W = $clog2(TICKS_PER_SEC);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICKS_PER_SEC - 1);

  logic [CNT_W-1:0] presc;

  // second prescaler
  always_ff @(posedge clk) begin
    if (rst) begin
      presc <= '0;
      tick  <= 1'b0;
    end else if (presc == CNT_LAST) begin
      presc <= '0;
      tick  <= 1'b1;  // single cycle pulse on wrap
    end else begin
      presc <= presc + 1'b1;
      tick  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mode_q <= mode_run;
    end else begin
      mode_q <= mode;
    end
  end

  // load levels last as long as the set mode
  assign load_time  = (mode_q == mode_set_time);
  assign load_timer = (mode_q == mode_set_timer);
  assign load_alarm = (mode_q == mode_set_alarm);

  // clock only runs in run mode
  assign time_step  = tick && (mode_q == mode_run);
  // timer keeps going unless it is being set
  assign timer_step = tick && (mode_q != mode_set_timer);

endmodule

// ==== logic/clock_pkg.sv ====
package clock_pkg;

  // operating mode, run is the reset value
  typedef enum logic [1:0] {
    mode_run       = 2'b00,
    mode_set_time  = 2'b01,
    mode_set_timer = 2'b10,
    mode_set_alarm = 2'b11
  } mode_e;

  // packed bcd time, hours in the top byte
  localparam int TIME_W = 24;  // hh:mm:ss
  localparam int HM_W   = 16;  // hh:mm only

  // field limits, all bcd
  localparam logic [7:0] BCD_MAX_MINSEC = 8'h59;
  localparam logic [7:0] BCD_MAX_HOUR   = 8'h23;
  localparam logic [7:0] BCD_NOON       = 8'h12;  // first pm hour

endpackage
